/* design/eth_mac_pkg.sv */
package eth_mac_pkg;

  // Host side buffer sizes
  localparam int TX_BUF_DEPTH = 16;
  localparam int RX_BUF_DEPTH = 32;

  // Wide enough to hold a full receive buffer of credits
  localparam int CREDIT_W = $clog2(RX_BUF_DEPTH + 1);

  typedef logic [7:0] byte_t;

  // Transmit buffer entry
  typedef struct packed {
    byte_t data;
    logic  last;  // Final byte of the frame
  } tx_item_t;

  // Receive buffer entry
  typedef struct packed {
    byte_t data;
    logic  last;
    logic  crc_ok;  // Only meaningful with last
  } rx_item_t;

endpackage

/* design/eth_mii_pkg.sv */
package eth_mii_pkg;

  typedef logic [3:0] nibble_t;  // One MII data transfer

  // Preamble is PREAMBLE_NIBBLES of PRE_NIBBLE, then SFD_NIBBLE
  localparam int      PREAMBLE_NIBBLES = 15;
  localparam nibble_t PRE_NIBBLE       = 4'h5;
  localparam nibble_t SFD_NIBBLE       = 4'hD;

  // Reflected IEEE 802.3 polynomial
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

  // Register value after a good frame and its FCS
  localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

  // Idle nibbles between frames
  localparam int IFG_NIBBLES = 24;

endpackage

/* design/eth_crc32.sv */
`timescale 1ns/1ps

module eth_crc32 (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 init_i,
  input  logic                 en_i,
  input  eth_mii_pkg::nibble_t nibble_i,
  output logic [31:0]          crc_o,
  output logic                 residue_ok_o
);

  import eth_mii_pkg::*;

  logic [31:0] crc_q;

  // Four reflected steps, LSB of the nibble first
  function automatic logic [31:0] crc_step(input logic [31:0] crc, input nibble_t nib);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 4; i++) begin
      if (c[0] ^ nib[i]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || init_i) begin
      crc_q <= '1;  // Preset to all ones
    end else if (en_i) begin
      crc_q <= crc_step(crc_q, nibble_i);
    end
  end

  assign crc_o        = crc_q;
  assign residue_ok_o = (crc_q == CRC_RESIDUE);

endmodule

/* design/eth_credit_buf.sv */
`timescale 1ns/1ps

module eth_credit_buf #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 16
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  item_t item_i,
  input  logic  pop_i,
  output item_t item_o,
  output logic  empty_o,
  output logic  full_o,
  output logic  credit_o
);

  localparam int AW = $clog2(DEPTH);

  item_t         mem_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          credit_q;

  // Storage, no reset
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_i;  // One credit back per item read
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign item_o   = mem_q[rd_ptr_q];  // First word falls through
  assign empty_o  = (count_q == '0);
  assign full_o   = (count_q == (AW + 1)'(DEPTH));
  assign credit_o = credit_q;

  // Upstream credit accounting must keep these from ever firing
  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("push into full buffer");
  no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o)
    else $error("pop from empty buffer");

endmodule

/* design/eth_tx.sv */
`timescale 1ns/1ps

module eth_tx (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  eth_mac_pkg::tx_item_t item_i,
  input  logic                  empty_i,
  output logic                  pop_o,
  output logic                  mii_tx_en_o,
  output eth_mii_pkg::nibble_t  mii_txd_o,
  output logic                  underrun_o
);

  import eth_mii_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PRE,
    ST_DLO,
    ST_DHI,
    ST_FCS,
    ST_GAP
  } state_t;

  state_t      state_q;
  logic [4:0]  cnt_q;  // Preamble, FCS and gap nibble count
  logic        bad_q;  // Frame hit an underrun
  logic [31:0] crc;
  logic [31:0] fcs;
  logic        crc_en;

  // Good frames send the inverted CRC, broken ones the raw value
  assign fcs        = bad_q ? crc : ~crc;
  assign underrun_o = (state_q == ST_DLO) && empty_i;
  assign pop_o      = (state_q == ST_DHI);  // Byte done after its high nibble
  assign crc_en     = ((state_q == ST_DLO) && !empty_i) || (state_q == ST_DHI);

  always_comb begin
    mii_tx_en_o = 1'b1;
    mii_txd_o   = '0;
    case (state_q)
      ST_PRE:  mii_txd_o = (cnt_q == 5'(PREAMBLE_NIBBLES)) ? SFD_NIBBLE : PRE_NIBBLE;
      ST_DLO:  mii_txd_o = item_i.data[3:0];
      ST_DHI:  mii_txd_o = item_i.data[7:4];
      ST_FCS:  mii_txd_o = fcs[{cnt_q[2:0], 2'b00} +: 4];  // Low nibble first
      default: mii_tx_en_o = 1'b0;
    endcase
  end

  eth_crc32 crc32 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_i      (state_q == ST_IDLE),
    .en_i        (crc_en),
    .nibble_i    (mii_txd_o),
    .crc_o       (crc),
    .residue_ok_o()
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      bad_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          bad_q <= 1'b0;
          if (!empty_i) begin
            state_q <= ST_PRE;
          end
        end
        ST_PRE: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == 5'(PREAMBLE_NIBBLES)) begin
            state_q <= ST_DLO;
          end
        end
        ST_DLO: begin
          cnt_q <= '0;
          if (empty_i) begin
            bad_q   <= 1'b1;    // Close the frame early
            state_q <= ST_FCS;
          end else begin
            state_q <= ST_DHI;
          end
        end
        ST_DHI: state_q <= item_i.last ? ST_FCS : ST_DLO;
        ST_FCS: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == 5'd7) begin
            cnt_q   <= '0;
            state_q <= ST_GAP;
          end
        end
        ST_GAP: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == 5'(IFG_NIBBLES - 1)) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Enable only drops right after the eighth FCS nibble
  tx_en_fcs_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(mii_tx_en_o) |-> $past(state_q == ST_FCS && cnt_q == 5'd7))
    else $error("tx enable dropped inside a frame");

endmodule

/* design/eth_rx.sv */
`timescale 1ns/1ps

module eth_rx (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  mii_rx_dv_i,
  input  eth_mii_pkg::nibble_t  mii_rxd_i,
  input  logic                  full_i,
  output logic                  push_o,
  output eth_mac_pkg::rx_item_t item_o,
  output logic                  overrun_o
);

  import eth_mii_pkg::*;
  import eth_mac_pkg::*;

  typedef enum logic [1:0] {
    ST_HUNT,
    ST_DATA,
    ST_WAIT
  } state_t;

  state_t     state_q;
  logic       pre_seen_q;  // At least one preamble nibble
  logic       phase_q;     // High nibble comes next
  nibble_t    lo_q;
  byte_t      hold_q [4];  // Holds back the FCS, entry 0 newest
  logic [2:0] held_q;
  byte_t      pend_q;      // Oldest data byte, may still be the last
  logic       pend_v_q;
  logic       push_q;
  rx_item_t   item_q;
  logic       residue_ok;
  logic       byte_done;
  logic       frame_end;

  assign byte_done = (state_q == ST_DATA) && mii_rx_dv_i && phase_q;
  assign frame_end = (state_q == ST_DATA) && !mii_rx_dv_i;

  // Receive side never stalls so a full buffer loses the byte
  assign push_o    = push_q && !full_i;
  assign overrun_o = push_q && full_i;
  assign item_o    = item_q;

  eth_crc32 crc32 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .init_i      (state_q == ST_HUNT),
    .en_i        ((state_q == ST_DATA) && mii_rx_dv_i),
    .nibble_i    (mii_rxd_i),
    .crc_o       (),
    .residue_ok_o(residue_ok)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_HUNT;
      pre_seen_q <= 1'b0;
      phase_q    <= 1'b0;
      held_q     <= '0;
      pend_v_q   <= 1'b0;
      push_q     <= 1'b0;
    end else begin
      push_q <= 1'b0;
      case (state_q)
        ST_HUNT: begin
          phase_q  <= 1'b0;
          held_q   <= '0;
          pend_v_q <= 1'b0;
          if (!mii_rx_dv_i) begin
            pre_seen_q <= 1'b0;
          end else if (mii_rxd_i == PRE_NIBBLE) begin
            pre_seen_q <= 1'b1;
          end else if (mii_rxd_i == SFD_NIBBLE && pre_seen_q) begin
            state_q <= ST_DATA;
          end else begin
            state_q <= ST_WAIT;  // Garbage, sit out this carrier
          end
        end
        ST_DATA: begin
          if (!mii_rx_dv_i) begin
            push_q     <= pend_v_q;  // Short frames never fill pend
            pre_seen_q <= 1'b0;
            state_q    <= ST_HUNT;
          end else begin
            phase_q <= !phase_q;
            if (phase_q) begin
              push_q   <= pend_v_q;
              pend_v_q <= (held_q == 3'd4);
              if (held_q != 3'd4) begin
                held_q <= held_q + 1'b1;
              end
            end
          end
        end
        default: begin
          pre_seen_q <= 1'b0;
          if (!mii_rx_dv_i) begin
            state_q <= ST_HUNT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == ST_DATA) && mii_rx_dv_i && !phase_q) begin
      lo_q <= mii_rxd_i;
    end
    if (byte_done) begin
      hold_q[0]     <= {mii_rxd_i, lo_q};
      hold_q[1]     <= hold_q[0];
      hold_q[2]     <= hold_q[1];
      hold_q[3]     <= hold_q[2];
      pend_q        <= hold_q[3];
      item_q.data   <= pend_q;
      item_q.last   <= 1'b0;
      item_q.crc_ok <= 1'b0;
    end else if (frame_end) begin
      item_q.data   <= pend_q;
      item_q.last   <= 1'b1;
      item_q.crc_ok <= residue_ok && !phase_q;  // Odd nibble count is bad
    end
  end

endmodule

/* design/eth_mac.sv */
`timescale 1ns/1ps

module eth_mac (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Host transmit
  input  logic                 tx_valid_i,
  input  eth_mac_pkg::byte_t   tx_data_i,
  input  logic                 tx_last_i,
  output logic                 tx_credit_o,
  output logic                 tx_underrun_o,
  // Host receive
  input  logic                 rx_credit_i,
  output logic                 rx_valid_o,
  output eth_mac_pkg::byte_t   rx_data_o,
  output logic                 rx_last_o,
  output logic                 rx_crc_ok_o,
  output logic                 rx_overrun_o,
  // MII
  output logic                 mii_tx_en_o,
  output eth_mii_pkg::nibble_t mii_txd_o,
  input  logic                 mii_rx_dv_i,
  input  eth_mii_pkg::nibble_t mii_rxd_i
);

  import eth_mac_pkg::*;

  tx_item_t            tx_push_item;
  tx_item_t            tx_head;
  logic                tx_empty;
  logic                tx_pop;
  rx_item_t            rx_push_item;
  rx_item_t            rx_head;
  logic                rx_push;
  logic                rx_full;
  logic                rx_empty;
  logic                rx_pop;
  logic                rx_grant;
  logic [CREDIT_W-1:0] rx_credits_q;
  logic                rx_valid_q;
  rx_item_t            rx_out_q;

  assign tx_push_item = '{data: tx_data_i, last: tx_last_i};

  eth_credit_buf #(.item_t(tx_item_t), .DEPTH(TX_BUF_DEPTH)) tx_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (tx_valid_i),
    .item_i  (tx_push_item),
    .pop_i   (tx_pop),
    .item_o  (tx_head),
    .empty_o (tx_empty),
    .full_o  (),
    .credit_o(tx_credit_o)  // Straight back to the host
  );

  eth_tx tx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .item_i     (tx_head),
    .empty_i    (tx_empty),
    .pop_o      (tx_pop),
    .mii_tx_en_o(mii_tx_en_o),
    .mii_txd_o  (mii_txd_o),
    .underrun_o (tx_underrun_o)
  );

  eth_rx rx (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mii_rx_dv_i(mii_rx_dv_i),
    .mii_rxd_i  (mii_rxd_i),
    .full_i     (rx_full),
    .push_o     (rx_push),
    .item_o     (rx_push_item),
    .overrun_o  (rx_overrun_o)
  );

  eth_credit_buf #(.item_t(rx_item_t), .DEPTH(RX_BUF_DEPTH)) rx_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rx_push),
    .item_i  (rx_push_item),
    .pop_i   (rx_pop),
    .item_o  (rx_head),
    .empty_o (rx_empty),
    .full_o  (rx_full),
    .credit_o()
  );

  // Deliver only against a host credit
  assign rx_pop   = (rx_credits_q != '0) && !rx_empty;
  // Saturate, unless a delivery frees a slot this cycle
  assign rx_grant = rx_credit_i && ((rx_credits_q != CREDIT_W'(RX_BUF_DEPTH)) || rx_pop);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_credits_q <= '0;
      rx_valid_q   <= 1'b0;
    end else begin
      rx_valid_q <= rx_pop;
      case ({rx_grant, rx_pop})
        2'b10:   rx_credits_q <= rx_credits_q + 1'b1;
        2'b01:   rx_credits_q <= rx_credits_q - 1'b1;
        default: rx_credits_q <= rx_credits_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_pop) begin
      rx_out_q <= rx_head;
    end
  end

  assign rx_valid_o  = rx_valid_q;
  assign rx_data_o   = rx_out_q.data;
  assign rx_last_o   = rx_out_q.last;
  assign rx_crc_ok_o = rx_out_q.crc_ok;

endmodule

/* bench/eth_mac_model.svh */
`ifndef ETH_MAC_MODEL_SVH
`define ETH_MAC_MODEL_SVH

localparam logic [31:0] MODEL_POLY = 32'hEDB8_8320;  // IEEE 802.3, reflected

// Bit-serial CRC over whole bytes, LSB first, no final inversion
function automatic logic [31:0] frame_crc(input byte_t frame[$]);
  logic [31:0] crc;
  crc = '1;
  foreach (frame[i]) begin
    for (int b = 0; b < 8; b++) begin
      if (crc[0] ^ frame[i][b]) begin
        crc = (crc >> 1) ^ MODEL_POLY;
      end else begin
        crc = crc >> 1;
      end
    end
  end
  return crc;
endfunction

// Wire image: preamble, SFD, data and FCS, each byte low nibble first
task automatic expand_frame(input byte_t frame[$], ref nibble_t nibs[$]);
  logic [31:0] fcs;
  fcs = ~frame_crc(frame);
  nibs.delete();
  repeat (PREAMBLE_NIBBLES) nibs.push_back(4'h5);
  nibs.push_back(SFD_NIBBLE);
  foreach (frame[i]) begin
    nibs.push_back(frame[i][3:0]);
    nibs.push_back(frame[i][7:4]);
  end
  for (int k = 0; k < 8; k++) begin
    nibs.push_back(fcs[4*k +: 4]);
  end
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
  if (act !== exp) begin
    report_failure($sformatf("error %0t %s expected %h got %h", $time, name, exp, act));
  end
endtask

task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
  if (act !== exp) begin
    report_failure($sformatf("error %0t %s expected %h got %h", $time, name, exp, act));
  end
endtask

task automatic check_flag(input string name, input bit exp, input bit act);
  if (act !== exp) begin
    report_failure($sformatf("error %0t %s expected %b got %b", $time, name, exp, act));
  end
endtask

`endif

/* bench/eth_mac_tb.sv */
`timescale 1ns/1ps

module eth_mac_tb;

  import eth_mac_pkg::*;
  import eth_mii_pkg::*;

  localparam int LOOP_FRAMES = 12;
  localparam int TAIL_FRAMES = 4;
  localparam int WAIT_LIMIT  = 20000;  // Cycles per wait

  logic    clk_i, rst_n_i;
  logic    tx_valid_i, tx_last_i, tx_credit_o, tx_underrun_o;
  byte_t   tx_data_i;
  logic    rx_credit_i, rx_valid_o, rx_last_o, rx_crc_ok_o, rx_overrun_o;
  byte_t   rx_data_o;
  logic    mii_tx_en_o, mii_rx_dv_i;
  nibble_t mii_txd_o, mii_rxd_i;

  integer     seed = 32'ha2f6;
  logic       checking;
  logic       hold_credits;  // Host keeps its rx credits back
  logic       inject_mode;   // MII receive fed from inject_q
  tx_item_t   tx_queue[$];   // Bytes waiting for a host credit
  nibble_t    exp_nibs[$];
  int         exp_lens[$];
  byte_t      exp_data[$];
  logic       exp_last[$];
  logic       exp_ok[$];
  logic [4:0] inject_q[$];   // {dv, nibble} per cycle
  int         tx_credits, bytes_sent, credits_back;
  int         frames_sent, frames_done;
  int         granted, delivered, expected_total;

  eth_mac UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  `include "eth_mac_model.svh"

  task automatic wait_for_count(ref int count, input int target, input string what);
    int cycles;
    cycles = 0;
    while (count != target) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        report_failure({"timeout: ", what});
      end
    end
  endtask

  task automatic build_frame(ref byte_t frame[$], input int max_len);
    int len;
    len = 6 + $unsigned($random(seed)) % (max_len - 5);
    frame.delete();
    for (int i = 0; i < len; i++) begin
      frame.push_back(byte_t'($random(seed)));
    end
  endtask

  task automatic expect_rx(input byte_t frame[$], input logic ok);
    foreach (frame[i]) begin
      exp_data.push_back(frame[i]);
      exp_last.push_back(i == frame.size() - 1);
      exp_ok.push_back(ok);
    end
    expected_total += frame.size();
  endtask

  // Queue a frame for the host driver and expect it on MII and back at the host
  task automatic send_frame(input int max_len);
    byte_t   frame[$];
    nibble_t nibs[$];
    @(posedge clk_i);
    build_frame(frame, max_len);
    expand_frame(frame, nibs);
    foreach (nibs[i]) exp_nibs.push_back(nibs[i]);
    exp_lens.push_back(nibs.size());
    foreach (frame[i]) begin
      tx_queue.push_back(tx_item_t'{data: frame[i], last: (i == frame.size() - 1)});
    end
    expect_rx(frame, 1'b1);
    frames_sent++;
  endtask

  task automatic inject_frame(input logic corrupt);
    byte_t   frame[$];
    nibble_t nibs[$];
    int      pos;
    build_frame(frame, 40);
    expand_frame(frame, nibs);
    if (corrupt) begin
      pos = $unsigned($random(seed)) % (2 * frame.size());
      nibs[PREAMBLE_NIBBLES + 1 + pos] ^= 4'hF;  // FCS still from clean data
      frame[pos / 2] ^= (pos % 2) ? 8'hF0 : 8'h0F;
    end
    foreach (nibs[i]) inject_q.push_back({1'b1, nibs[i]});
    repeat (IFG_NIBBLES) inject_q.push_back(5'h00);
    expect_rx(frame, !corrupt);
  endtask

  // Host transmit driver, one byte per cycle while credit lasts
  initial begin
    tx_valid_i   = 1'b0;
    tx_data_i    = '0;
    tx_last_i    = 1'b0;
    tx_credits   = TX_BUF_DEPTH;
    bytes_sent   = 0;
    credits_back = 0;
    forever begin
      @(negedge clk_i);
      tx_valid_i = 1'b0;
      if (checking && tx_credit_o) begin
        tx_credits++;
        credits_back++;
      end
      if (checking && tx_credits > 0 && tx_queue.size() > 0) begin
        {tx_data_i, tx_last_i} = tx_queue.pop_front();
        tx_valid_i = 1'b1;
        tx_credits--;
        bytes_sent++;
      end
    end
  end

  // MII transmit checker
  initial begin
    int burst;
    int idle;
    burst       = 0;
    idle        = IFG_NIBBLES;
    frames_done = 0;
    forever begin
      @(negedge clk_i);
      if (checking) begin
        check_flag("tx_underrun_o", 1'b0, tx_underrun_o);
        check_flag("rx_overrun_o", 1'b0, rx_overrun_o);
        if (mii_tx_en_o) begin
          if (burst == 0 && idle < IFG_NIBBLES) begin
            report_failure("inter-frame gap on mii_tx_en_o is too short");
          end
          if (exp_nibs.size() == 0) begin
            report_failure("mii_tx_en_o went high with no frame queued");
          end
          check_nibble("mii_txd_o", exp_nibs.pop_front(), mii_txd_o);
          burst++;
          idle = 0;
        end else begin
          if (burst != 0) begin
            if (burst != exp_lens.pop_front()) begin
              report_failure("transmitted frame has the wrong number of nibbles");
            end
            frames_done++;
          end
          burst = 0;
          idle++;
        end
      end
    end
  end

  // Loopback, or model nibbles while injecting
  initial begin
    mii_rx_dv_i = 1'b0;
    mii_rxd_i   = '0;
    forever begin
      @(negedge clk_i);
      if (!inject_mode) begin
        mii_rx_dv_i = mii_tx_en_o;
        mii_rxd_i   = mii_txd_o;
      end else if (inject_q.size() > 0) begin
        {mii_rx_dv_i, mii_rxd_i} = inject_q.pop_front();
      end else begin
        mii_rx_dv_i = 1'b0;
        mii_rxd_i   = '0;
      end
    end
  end

  // Host receive side
  initial begin
    int   pending;
    logic last_exp;
    logic ok_exp;
    rx_credit_i = 1'b0;
    granted     = 0;
    delivered   = 0;
    forever begin
      @(negedge clk_i);
      rx_credit_i = 1'b0;
      if (checking) begin
        if (hold_credits) begin
          check_flag("rx_valid_o", 1'b0, rx_valid_o);
        end
        if (rx_valid_o) begin
          delivered++;
          if (delivered > granted) begin
            report_failure("host received more bytes than it granted credits");
          end
          if (exp_data.size() == 0) begin
            report_failure("host received a byte that was never sent");
          end
          last_exp = exp_last.pop_front();
          ok_exp   = exp_ok.pop_front();
          check_byte("rx_data_o", exp_data.pop_front(), rx_data_o);
          check_flag("rx_last_o", last_exp, rx_last_o);
          if (last_exp) begin
            check_flag("rx_crc_ok_o", ok_exp, rx_crc_ok_o);
          end
        end
        // Never more credits out than bytes expected, nor than the buffer holds
        pending = (exp_data.size() > RX_BUF_DEPTH) ? RX_BUF_DEPTH : exp_data.size();
        if (!hold_credits && granted - delivered < pending && ($random(seed) & 3) != 0) begin
          rx_credit_i = 1'b1;
          granted++;
        end
      end
    end
  end

  initial begin
    rst_n_i        = 1'b0;
    checking       = 1'b0;
    hold_credits   = 1'b0;
    inject_mode    = 1'b0;
    frames_sent    = 0;
    expected_total = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(posedge clk_i);
    checking = 1'b1;
    repeat (5) begin
      @(negedge clk_i);
      check_flag("tx_credit_o", 1'b0, tx_credit_o);
      check_flag("rx_valid_o", 1'b0, rx_valid_o);
      check_flag("mii_tx_en_o", 1'b0, mii_tx_en_o);
      check_flag("tx_underrun_o", 1'b0, tx_underrun_o);
      check_flag("rx_overrun_o", 1'b0, rx_overrun_o);
      check_nibble("mii_txd_o", 4'h0, mii_txd_o);
    end
    repeat (LOOP_FRAMES) send_frame(40);
    wait_for_count(delivered, expected_total, "loopback bytes never all reached the host");
    // Held frame must wait in the receive buffer
    hold_credits = 1'b1;
    send_frame(30);
    wait_for_count(frames_done, frames_sent, "held frame never left the transmitter");
    repeat (IFG_NIBBLES) @(posedge clk_i);
    hold_credits = 1'b0;
    wait_for_count(delivered, expected_total, "held frame never reached the host");
    inject_frame(1'b1);
    inject_frame(1'b0);
    inject_mode = 1'b1;
    wait_for_count(delivered, expected_total, "injected frames never reached the host");
    inject_mode = 1'b0;
    repeat (TAIL_FRAMES) send_frame(40);
    wait_for_count(delivered, expected_total, "last frames never reached the host");
    wait_for_count(frames_done, frames_sent, "transmitter never finished its frames");
    wait_for_count(credits_back, bytes_sent, "transmit credits never all came back");
    $display("Simulation passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+bench
design/eth_mac_pkg.sv
design/eth_mii_pkg.sv
design/eth_crc32.sv
design/eth_credit_buf.sv
design/eth_tx.sv
design/eth_rx.sv
design/eth_mac.sv
bench/eth_mac_tb.sv

/* Bender.yml */
package:
  name: eth_mac

sources:
  - files:
      - design/eth_mac_pkg.sv
      - design/eth_mii_pkg.sv
      - design/eth_crc32.sv
      - design/eth_credit_buf.sv
      - design/eth_tx.sv
      - design/eth_rx.sv
      - design/eth_mac.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/eth_mac_tb.sv
